// ==== src.f ====
design/complete_pkg.sv
design/priority_select8.sv
design/fu_result_slot.sv
design/complete_stage.sv
design/complete_top.sv
testbench/complete_checker.sv
testbench/complete_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the completion stage testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert -Wno-fatal --top-module complete_tb -f src.f -o complete_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/complete_sim > sim.log 2>&1 || echo "SIMULATION FAILED" >> sim.log
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "result: fail"; exit 1; } || {
    echo "result: pass"
    exit 0
}

// ==== testbench/complete_tb.sv ====
`timescale 1ns/1ps

module complete_tb
    import complete_pkg::*;
();

    typedef struct packed {
        logic [num_fu-1:0]             picked;  // units granted this cycle.
        cdb_tags_t                     tags;
        complete_out_t [cdb_width-1:0] out;
    } ref_result_t;

    localparam int m_empty    = 0;
    localparam int m_pending  = 1;
    localparam int m_draining = 2;

    logic                          clock;
    logic                          reset;
    logic          [num_fu-1:0]    fu_result_valid;
    fu_result_t    [num_fu-1:0]    fu_result;
    logic          [num_fu-1:0]    fu_ready;
    cdb_tags_t                     cdb_tags;
    complete_out_t [cdb_width-1:0] complete_out;

    int                      m_state [num_fu];  // slot model.
    fu_result_t [num_fu-1:0] m_pkt;
    ref_result_t             expect_now;        // what the outputs show this cycle.

    integer seed = 20;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errors_at_start = 0;
    int load_count = 0;
    int done_count = 0;

    complete_top dut_i (
        .clock           (clock),
        .reset           (reset),
        .fu_result_valid (fu_result_valid),
        .fu_result       (fu_result),
        .fu_ready        (fu_ready),
        .cdb_tags        (cdb_tags),
        .complete_out    (complete_out)
    );

    bind complete_stage complete_checker stage_chk (
        .clock     (clock),
        .reset     (reset),
        .sel       (sel),
        .stall_vec (fu_c_stall),
        .load      (1'b0),
        .ready     (1'b1)
    );

    bind fu_result_slot complete_checker slot_chk (
        .clock     (clock),
        .reset     (reset),
        .sel       ('0),
        .stall_vec ('0),
        .load      (load),
        .ready     (ready)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // ############################################################
    // reference model
    // ############################################################

    function automatic complete_out_t expect_out(input fu_result_t r);
        complete_out_t o;
        o = '0;
        o.valid      = 1'b1;
        o.halt       = r.halt;
        o.dest_value = r.dest_value;
        o.rob_entry  = r.rob_entry;
        if (r.take_branch) begin
            o.take_branch = 1'b1;
            o.target_pc   = r.target_pc;  // target only travels when taken.
        end
        return o;
    endfunction

    // highest pending unit goes to channel 2, then 1, then 0.
    function automatic ref_result_t reference_complete(
        input logic       [num_fu-1:0] pending,
        input fu_result_t [num_fu-1:0] pkts
    );
        ref_result_t r;
        int          ch;
        r  = '0;
        ch = cdb_width - 1;
        for (int u = num_fu - 1; u >= 0; u--) begin
            if (pending[u] && ch >= 0) begin
                r.out[ch]    = expect_out(pkts[u]);
                r.picked[u]  = 1'b1;
                case (ch)
                    2: r.tags.t2 = pkts[u].dest_pr;
                    1: r.tags.t1 = pkts[u].dest_pr;
                    default: r.tags.t0 = pkts[u].dest_pr;
                endcase
                ch--;
            end
        end
        return r;
    endfunction

    function automatic logic [num_fu-1:0] pending_mask();
        logic [num_fu-1:0] m;
        for (int u = 0; u < num_fu; u++) begin
            m[u] = (m_state[u] == m_pending);
        end
        return m;
    endfunction

    function automatic logic model_idle();
        logic idle;
        idle = 1'b1;
        for (int u = 0; u < num_fu; u++) begin
            if (m_state[u] != m_empty) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    always @(posedge clock) begin : model_step
        if (reset) begin
            for (int u = 0; u < num_fu; u++) begin
                m_state[u] = m_empty;
            end
            expect_now = '0;
        end else begin
            expect_now = reference_complete(pending_mask(), m_pkt);
            for (int u = 0; u < num_fu; u++) begin
                if (m_state[u] == m_pending) begin
                    if (expect_now.picked[u]) begin
                        m_state[u] = m_draining;
                    end
                end else if (fu_result_valid[u]) begin
                    m_state[u] = m_pending;  // reload also ends a drain.
                    m_pkt[u]   = fu_result[u];
                    load_count++;
                end else begin
                    m_state[u] = m_empty;
                end
            end
        end
    end

    // ############################################################
    // compare
    // ############################################################

    task automatic check_complete(input string name, input complete_out_t got,
                                  input complete_out_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_tags(input cdb_tags_t got, input cdb_tags_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t cdb_tags got %h expected %h", $time, got, want);
        end
    endtask

    task automatic check_ready(input logic [num_fu-1:0] got, input logic [num_fu-1:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t fu_ready got %b expected %b", $time, got, want);
        end
    endtask

    always @(negedge clock) begin : compare_step
        if (!reset) begin
            for (int ch = 0; ch < cdb_width; ch++) begin
                check_complete($sformatf("complete_out[%0d]", ch), complete_out[ch],
                               expect_now.out[ch]);
                if (complete_out[ch].valid) begin
                    done_count++;
                end
            end
            check_tags(cdb_tags, expect_now.tags);
            check_ready(fu_ready, ~pending_mask());
        end
    end

    // ############################################################
    // stimulus
    // ############################################################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_ready(input int u);
        int n;
        n = 0;
        while (!fu_ready[u]) begin
            next_cycle();
            n++;
            if (n > 20) begin
                abort_run($sformatf("timeout: unit %0d never became ready", u));
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (!model_idle()) begin
            @(negedge clock);
            n++;
            if (n > 100) begin
                abort_run("timeout: results still waiting after 100 cycles");
            end
        end
    endtask

    task automatic load_units(input logic [num_fu-1:0] mask,
                              input fu_result_t [num_fu-1:0] pkts);
        for (int u = 0; u < num_fu; u++) begin
            if (mask[u]) begin
                wait_ready(u);
            end
        end
        fu_result       = pkts;
        fu_result_valid = mask;
        next_cycle();
        fu_result_valid = '0;
    endtask

    function automatic fu_result_t make_result(
        input logic                halt,
        input logic                take,
        input logic [xlen-1:0]     target,
        input logic [pr_bits-1:0]  dest,
        input logic [xlen-1:0]     value,
        input logic [rob_bits-1:0] rob
    );
        fu_result_t p;
        p = '{valid: 1'b1, halt: halt, take_branch: take, target_pc: target,
              dest_pr: dest, dest_value: value, rob_entry: rob};
        return p;
    endfunction

    function automatic fu_result_t random_packet(input int u);
        fu_result_t p;
        p = '0;
        p.valid      = 1'b1;
        p.halt       = (($random(seed) & 15) == 0);
        p.target_pc  = $random(seed);
        p.dest_pr    = 6'($random(seed));
        p.dest_value = $random(seed);
        p.rob_entry  = 5'($random(seed));
        if (p.dest_pr == '0) begin
            p.dest_pr = 6'd1;  // zero tag would read as an idle channel.
        end
        if (u == num_fu - 1) begin
            p.take_branch = 1'($random(seed));
        end
        return p;
    endfunction

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d mismatches", tests_run, name, errors - errors_at_start);
        end
    endtask

    initial begin : run_tests
        fu_result_t    [num_fu-1:0] pkts;
        fu_result_t    p_a;
        fu_result_t    p_b;
        complete_out_t want;
        cdb_tags_t     tags;

        reset           = 1'b1;
        fu_result_valid = '0;
        fu_result       = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test();
        @(negedge clock);
        for (int ch = 0; ch < cdb_width; ch++) begin
            check_complete($sformatf("complete_out[%0d]", ch), complete_out[ch], '0);
        end
        check_tags(cdb_tags, '0);
        check_ready(fu_ready, '1);
        end_test("reset state");

        start_test();
        next_cycle();
        pkts    = '0;
        pkts[3] = make_result(1'b1, 1'b0, 32'h0, 6'd5, 32'hdead_0003, 5'd9);
        load_units(8'h08, pkts);
        @(negedge clock);  // pending, nothing on the bus yet.
        check_complete("complete_out[2]", complete_out[2], '0);
        @(negedge clock);
        check_complete("complete_out[2]", complete_out[2], expect_out(pkts[3]));
        tags    = '0;
        tags.t2 = 6'd5;
        check_tags(cdb_tags, tags);
        end_test("single result on unit 3");

        start_test();
        next_cycle();
        pkts    = '0;
        pkts[7] = make_result(1'b0, 1'b1, 32'h0000_4a80, 6'd7, 32'h0000_0077, 5'd3);
        pkts[6] = make_result(1'b0, 1'b0, 32'h1234_5678, 6'd8, 32'h0000_0066, 5'd6);
        load_units(8'hc0, pkts);
        @(negedge clock);
        @(negedge clock);
        want             = '0;
        want.valid       = 1'b1;
        want.take_branch = 1'b1;
        want.target_pc   = 32'h0000_4a80;
        want.dest_value  = 32'h0000_0077;
        want.rob_entry   = 5'd3;
        check_complete("complete_out[2]", complete_out[2], want);
        want            = '0;
        want.valid      = 1'b1;
        want.dest_value = 32'h0000_0066;
        want.rob_entry  = 5'd6;
        check_complete("complete_out[1]", complete_out[1], want);
        end_test("branch target");

        start_test();
        next_cycle();
        pkts = '0;
        for (int u = 0; u < num_fu; u++) begin
            pkts[u] = make_result(1'b0, 1'b0, 32'h0, 6'(10 + u), 32'h100 + u, 5'(u));
        end
        load_units(8'h75, pkts);
        @(negedge clock);
        check_ready(fu_ready, 8'h8a);
        @(negedge clock);
        check_complete("complete_out[2]", complete_out[2], expect_out(pkts[6]));
        check_complete("complete_out[1]", complete_out[1], expect_out(pkts[5]));
        check_complete("complete_out[0]", complete_out[0], expect_out(pkts[4]));
        check_ready(fu_ready, 8'hfa);  // units 2 and 0 still stalled.
        @(negedge clock);
        check_complete("complete_out[2]", complete_out[2], expect_out(pkts[2]));
        check_complete("complete_out[1]", complete_out[1], expect_out(pkts[0]));
        check_complete("complete_out[0]", complete_out[0], '0);
        check_ready(fu_ready, 8'hff);
        end_test("five units at once");

        start_test();
        next_cycle();
        for (int cyc = 0; cyc < 300; cyc++) begin
            for (int u = 0; u < num_fu; u++) begin
                fu_result_valid[u] = 1'b0;
                if (fu_ready[u] && ($random(seed) & 1)) begin
                    fu_result[u]       = random_packet(u);
                    fu_result_valid[u] = 1'b1;
                end
            end
            next_cycle();
        end
        fu_result_valid = '0;
        wait_idle();
        @(negedge clock);
        if (load_count != done_count) begin
            errors++;
            $display("loaded %0d results but %0d completed", load_count, done_count);
        end
        end_test("random loads");

        start_test();
        next_cycle();
        p_a     = make_result(1'b0, 1'b0, 32'h0, 6'd21, 32'haaaa_0001, 5'd17);
        p_b     = make_result(1'b0, 1'b0, 32'h0, 6'd22, 32'hbbbb_0002, 5'd18);
        pkts    = '0;
        pkts[1] = p_a;
        load_units(8'h02, pkts);
        next_cycle();  // first result drains now.
        check_ready(fu_ready, 8'hff);
        fu_result[1]    = p_b;
        fu_result_valid = 8'h02;
        @(negedge clock);
        check_complete("complete_out[2]", complete_out[2], expect_out(p_a));
        next_cycle();
        fu_result_valid = '0;
        @(negedge clock);
        check_complete("complete_out[2]", complete_out[2], '0);
        check_ready(fu_ready, 8'hfd);
        @(negedge clock);
        check_complete("complete_out[2]", complete_out[2], expect_out(p_b));
        end_test("reload on drain");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/complete_checker.sv ====
`timescale 1ns/1ps

module complete_checker
    import complete_pkg::*;
(
    input logic                             clock,
    input logic                             reset,
    input logic [cdb_width-1:0][num_fu-1:0] sel,
    input logic [num_fu-1:0]                stall_vec,
    input logic                             load,
    input logic                             ready
);

    logic [num_fu-1:0] granted;

    assign granted = sel[0] | sel[1] | sel[2];  // any channel picked the unit.

    // ############################################################
    // stage rules
    // ############################################################

    a_grant_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(sel[0]) && $onehot0(sel[1]) && $onehot0(sel[2])
    ) else $error("a channel granted more than one unit");

    a_grant_disjoint: assert property (@(posedge clock) disable iff (reset)
        ((sel[0] & sel[1]) == '0) && ((sel[0] & sel[2]) == '0) && ((sel[1] & sel[2]) == '0)
    ) else $error("two channels granted the same unit");

    // a unit may only wait when every channel is taken.
    a_stall_full: assert property (@(posedge clock) disable iff (reset)
        (stall_vec != '0) |-> ($countones(granted) == cdb_width)
    ) else $error("a unit was stalled while a channel stayed free");

    // ############################################################
    // slot rules
    // ############################################################

    a_load_ready: assert property (@(posedge clock) disable iff (reset)
        load |-> ready
    ) else $error("result loaded into a slot that was still pending");

endmodule

// ==== design/complete_top.sv ====
`timescale 1ns/1ps

module complete_top
    import complete_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic          [num_fu-1:0]     fu_result_valid,
    input  fu_result_t    [num_fu-1:0]     fu_result,
    output logic          [num_fu-1:0]     fu_ready,
    output cdb_tags_t                      cdb_tags,
    output complete_out_t [cdb_width-1:0]  complete_out
);

    logic       [num_fu-1:0] fu_finish;    // slot pending.
    logic       [num_fu-1:0] fu_stall;     // pending but not picked.
    fu_result_t [num_fu-1:0] slot_result;

    // ############################################################
    // one result slot per functional unit
    // ############################################################

    for (genvar u = 0; u < num_fu; u++) begin : g_slot
        fu_result_slot u_slot (
            .clock      (clock),
            .reset      (reset),
            .load       (fu_result_valid[u]),
            .result_in  (fu_result[u]),
            .stall      (fu_stall[u]),
            .finish     (fu_finish[u]),
            .ready      (fu_ready[u]),
            .result_out (slot_result[u])
        );
    end

    // ############################################################
    // completion stage
    // ############################################################

    complete_stage u_stage (
        .clock        (clock),
        .reset        (reset),
        .fu_finish    (fu_finish),
        .fu_c_in      (slot_result),
        .fu_c_stall   (fu_stall),
        .cdb_tags     (cdb_tags),
        .complete_out (complete_out)
    );

endmodule

// ==== design/complete_stage.sv ====
`timescale 1ns/1ps

module complete_stage
    import complete_pkg::*;
(
    input  logic                           clock,
    input  logic                           reset,
    input  logic          [num_fu-1:0]     fu_finish,
    input  fu_result_t    [num_fu-1:0]     fu_c_in,
    output logic          [num_fu-1:0]     fu_c_stall,
    output cdb_tags_t                      cdb_tags,
    output complete_out_t [cdb_width-1:0]  complete_out
);

    // ############################################################
    // selection
    // ############################################################

    // req_left[cdb_width] is the raw finish vector, each channel
    // removes its own grant before the next channel looks.
    logic [cdb_width:0][num_fu-1:0]   req_left;
    logic [cdb_width-1:0][num_fu-1:0] sel;

    assign req_left[cdb_width] = fu_finish;

    for (genvar ch = cdb_width - 1; ch >= 0; ch--) begin : g_sel
        priority_select8 u_select (
            .req (req_left[ch+1]),
            .gnt (sel[ch])
        );

        assign req_left[ch] = req_left[ch+1] & ~sel[ch];
    end

    // whatever no channel picked has to wait.
    assign fu_c_stall = req_left[0];

    // ############################################################
    // grant registers
    // ############################################################

    logic [cdb_width-1:0][fu_idx_bits-1:0] grant_idx;
    logic [cdb_width-1:0][fu_idx_bits-1:0] grant_next;

    always_comb begin
        grant_next = {cdb_width{fu_idx_none}};
        for (int ch = 0; ch < cdb_width; ch++) begin
            for (int i = 0; i < num_fu; i++) begin
                if (sel[ch][i]) begin
                    grant_next[ch] = fu_idx_bits'(i);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            grant_idx <= {cdb_width{fu_idx_none}};
        end else begin
            grant_idx <= grant_next;
        end
    end

    // ############################################################
    // output muxes
    // ############################################################

    logic       [cdb_width-1:0]              grant_valid;
    fu_result_t [cdb_width-1:0]              pick;
    logic       [cdb_width-1:0][pr_bits-1:0] tag;

    // the granted slot is draining now, so its packet is stable.
    always_comb begin
        for (int ch = 0; ch < cdb_width; ch++) begin
            grant_valid[ch] = ~grant_idx[ch][fu_sel_bits];
            pick[ch]        = fu_c_in[grant_idx[ch][fu_sel_bits-1:0]];

            complete_out[ch] = '0;
            tag[ch]          = '0;

            if (grant_valid[ch]) begin
                complete_out[ch].valid      = 1'b1;
                complete_out[ch].halt       = pick[ch].halt;
                complete_out[ch].dest_value = pick[ch].dest_value;
                complete_out[ch].rob_entry  = pick[ch].rob_entry;
                tag[ch]                     = pick[ch].dest_pr;

                // redirect only for a taken branch.
                if (pick[ch].take_branch) begin
                    complete_out[ch].take_branch = 1'b1;
                    complete_out[ch].target_pc   = pick[ch].target_pc;
                end
            end
        end
    end

    assign cdb_tags.t2 = tag[2];
    assign cdb_tags.t1 = tag[1];
    assign cdb_tags.t0 = tag[0];

endmodule

// ==== design/fu_result_slot.sv ====
`timescale 1ns/1ps

module fu_result_slot
    import complete_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       load,
    input  fu_result_t result_in,
    input  logic       stall,
    output logic       finish,
    output logic       ready,
    output fu_result_t result_out
);

    localparam logic [1:0] st_empty    = 2'd0;
    localparam logic [1:0] st_pending  = 2'd1;  // waiting for a channel.
    localparam logic [1:0] st_draining = 2'd2;  // stage reads the packet.

    logic [1:0] state;
    logic [1:0] state_next;
    logic       take;
    fu_result_t held;

    // a load is only accepted while the slot is not pending.
    assign take = load & ready;

    always_comb begin
        state_next = state;
        case (state)
            st_empty: begin
                if (take) begin
                    state_next = st_pending;
                end
            end
            st_pending: begin
                if (!stall) begin
                    state_next = st_draining;  // granted this cycle.
                end
            end
            st_draining: begin
                // back to back reload keeps the slot busy.
                if (take) begin
                    state_next = st_pending;
                end else begin
                    state_next = st_empty;
                end
            end
            default: begin
                state_next = st_empty;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_empty;
        end else begin
            state <= state_next;
        end
    end

    // the packet stays put through pending and draining.
    always_ff @(posedge clock) begin
        if (take) begin
            held <= result_in;
        end
    end

    assign finish     = (state == st_pending);
    assign ready      = (state != st_pending);
    assign result_out = held;

endmodule

// ==== design/priority_select8.sv ====
`timescale 1ns/1ps

module priority_select8 (
    input  logic [7:0] req,
    output logic [7:0] gnt
);

    logic [3:0] pair_any;  // some request inside each pair.
    logic [1:0] quad_any;  // some request inside each quad.
    logic [1:0] quad_en;
    logic [3:0] pair_en;

    // three levels of two-way selectors, upper half always wins
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            pair_any[k] = req[2*k] | req[2*k+1];
        end

        for (int q = 0; q < 2; q++) begin
            quad_any[q] = pair_any[2*q] | pair_any[2*q+1];
        end

        // top level.
        quad_en[1] = quad_any[1];
        quad_en[0] = quad_any[0] & ~quad_any[1];

        // middle level, gated by the quad that won.
        for (int q = 0; q < 2; q++) begin
            pair_en[2*q+1] = quad_en[q] & pair_any[2*q+1];
            pair_en[2*q]   = quad_en[q] & pair_any[2*q] & ~pair_any[2*q+1];
        end

        // leaf level.
        for (int k = 0; k < 4; k++) begin
            gnt[2*k+1] = pair_en[k] & req[2*k+1];
            gnt[2*k]   = pair_en[k] & req[2*k] & ~req[2*k+1];
        end
    end

endmodule

// ==== design/complete_pkg.sv ====
package complete_pkg;

    // ############################################################
    // widths and counts
    // ############################################################

    localparam int xlen      = 32;  // data and pc width.
    localparam int pr_bits   = 6;   // physical register tag.
    localparam int rob_bits  = 5;   // reorder buffer index.
    localparam int num_fu    = 8;   // 7 is the branch unit, 0 and 1 are alus.
    localparam int cdb_width = 3;   // broadcast channels.

    // a grant index carries one bit more than a unit number needs.
    // with that bit set the channel holds no grant.
    localparam int fu_sel_bits = $clog2(num_fu);
    localparam int fu_idx_bits = fu_sel_bits + 1;

    localparam logic [fu_idx_bits-1:0] fu_idx_none = '1;  // empty channel.

    // ############################################################
    // packets
    // ############################################################

    // what a functional unit hands over when it finishes.
    typedef struct packed {
        logic                valid;
        logic                halt;
        logic                take_branch;  // branch resolved taken.
        logic [xlen-1:0]     target_pc;    // corrected pc when taken.
        logic [pr_bits-1:0]  dest_pr;
        logic [xlen-1:0]     dest_value;
        logic [rob_bits-1:0] rob_entry;
    } fu_result_t;

    // one completion channel towards the reorder buffer.
    typedef struct packed {
        logic                valid;
        logic                halt;
        logic                take_branch;
        logic [xlen-1:0]     target_pc;    // zero unless taken.
        logic [xlen-1:0]     dest_value;
        logic [rob_bits-1:0] rob_entry;
    } complete_out_t;

    // destination tags on the common data bus, zero when a channel is idle.
    typedef struct packed {
        logic [pr_bits-1:0] t2;
        logic [pr_bits-1:0] t1;
        logic [pr_bits-1:0] t0;
    } cdb_tags_t;

endpackage
